/* verilog/pkt_port_settings.svh */
// Packet port settings
// Widths of the stream word, sequence number and control addresses, plus the
// settings and readback register map

`ifndef PKT_PORT_SETTINGS_SVH
`define PKT_PORT_SETTINGS_SVH

`default_nettype none

// Datapath widths
`define PP_WORD_W 64
`define PP_SEQ_W 12
`define PP_ADDR_W 8

// Settings bus addresses
`define PP_REG_CFG 8'd0
`define PP_REG_CLEAR 8'd1

// Readback bus addresses
`define PP_RB_CFG 8'd0
`define PP_RB_COUNTS 8'd1

`default_nettype wire

`endif

/* verilog/pkt_port_pkg.sv */
// Packet port types
// Route encoding for the inbound demux and the layout of a packet header word

`include "pkt_port_settings.svh"

`default_nettype none

package pkt_port_pkg;

  // Bit 0 selects the processing port, bit 1 the raw port
  typedef enum logic [1:0] {
    ROUTE_NONE = 2'd0,
    ROUTE_PROC = 2'd1,
    ROUTE_RAW  = 2'd2,
    ROUTE_BOTH = 2'd3
  } route_t;

  // First word of every packet, MSB first
  typedef struct packed {
    logic [3:0]           pkt_type;
    logic [`PP_SEQ_W-1:0] seqnum;
    logic [15:0]          pkt_len;
    logic [31:0]          sid;
  } pkt_hdr_t;

endpackage

`default_nettype wire

/* verilog/pkt_stream_if.sv */
// Packet stream interface
// One 64-bit word per transfer with valid/ready handshake and end of packet

`timescale 1ns/1ns
`include "pkt_port_settings.svh"
`default_nettype none

interface pkt_stream_if;

  logic [`PP_WORD_W-1:0] tdata;
  logic                  tlast;
  logic                  tvalid;
  logic                  tready;

  modport source (output tdata, output tlast, output tvalid, input tready);

  modport sink (input tdata, input tlast, input tvalid, output tready);

  // Passive tap for counters and checkers
  modport monitor (input tdata, input tlast, input tvalid, input tready);

endinterface

`default_nettype wire

/* verilog/port_ctrl.sv */
// Packet port control
// Settings decode, clear pulse, packet counters and registered readback

`timescale 1ns/1ns
`include "pkt_port_settings.svh"
`default_nettype none

module port_ctrl
  import pkt_port_pkg::*;
(
  input  wire                   ce_clk,
  input  wire                   i_rst_n,
  input  wire                   i_set_stb,
  input  wire [`PP_ADDR_W-1:0]  i_set_addr,
  input  wire [31:0]            i_set_data,
  input  wire                   i_rb_stb,
  input  wire [`PP_ADDR_W-1:0]  i_rb_addr,
  output logic                  o_rb_ack,
  output logic [63:0]           o_rb_data,
  output logic                  o_clear,
  output logic                  o_rewrite_en,
  input  wire                   i_done_stb,
  input  wire route_t           i_done_route,
  input  wire [`PP_SEQ_W-1:0]   i_seq_count,
  pkt_stream_if.monitor         net_mon
);

  logic [31:0] cfg_r;
  logic        clear_r;
  logic [15:0] in_cnt_r;
  logic [15:0] proc_cnt_r;
  logic [15:0] raw_cnt_r;
  logic        in_last;
  logic        done_proc;
  logic        done_raw;
  logic [63:0] rb_mux;

  //////////////////////////////////////////////////
  // Settings registers
  //////////////////////////////////////////////////
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      cfg_r   <= '0;
      clear_r <= 1'b0;
    end else begin
      // Clear is a single-cycle pulse, data ignored
      clear_r <= i_set_stb & (i_set_addr == `PP_REG_CLEAR);
      if (i_set_stb && (i_set_addr == `PP_REG_CFG)) begin
        cfg_r <= i_set_data;
      end
    end
  end

  assign o_clear      = clear_r;
  assign o_rewrite_en = cfg_r[0];

  //////////////////////////////////////////////////
  // Packet counters
  //////////////////////////////////////////////////
  assign in_last   = net_mon.tvalid & net_mon.tready & net_mon.tlast;
  // A packet sent to both ports counts on both routes
  assign done_proc = i_done_stb & ((i_done_route == ROUTE_PROC) | (i_done_route == ROUTE_BOTH));
  assign done_raw  = i_done_stb & ((i_done_route == ROUTE_RAW) | (i_done_route == ROUTE_BOTH));

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      in_cnt_r   <= '0;
      proc_cnt_r <= '0;
      raw_cnt_r  <= '0;
    end else if (clear_r) begin
      in_cnt_r   <= '0;
      proc_cnt_r <= '0;
      raw_cnt_r  <= '0;
    end else begin
      if (in_last)   in_cnt_r   <= in_cnt_r + 16'd1;
      if (done_proc) proc_cnt_r <= proc_cnt_r + 16'd1;
      if (done_raw)  raw_cnt_r  <= raw_cnt_r + 16'd1;
    end
  end

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////
  always_comb begin
    case (i_rb_addr)
      `PP_RB_CFG:    rb_mux = {32'd0, cfg_r};
      `PP_RB_COUNTS: rb_mux = {4'd0, i_seq_count, raw_cnt_r, proc_cnt_r, in_cnt_r};
      default:       rb_mux = '0;
    endcase
  end

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_rb_ack <= 1'b0;
    end else begin
      o_rb_ack <= i_rb_stb;
    end
  end

  // Data only updates on a strobe
  always_ff @(posedge ce_clk) begin
    if (i_rb_stb) begin
      o_rb_data <= rb_mux;
    end
  end

endmodule

`default_nettype wire

/* verilog/sink_steer.sv */
// Inbound packet steering
// Holds each header until a consumer is ready, then sends the whole packet to
// the processing port, the raw port, or both in lockstep

`timescale 1ns/1ns
`default_nettype none

module sink_steer
  import pkt_port_pkg::*;
(
  input  wire           ce_clk,
  input  wire           i_rst_n,
  input  wire           i_clear,
  pkt_stream_if.sink    net_in,
  pkt_stream_if.source  proc_out,
  pkt_stream_if.source  raw_out,
  output logic          o_done_stb,
  output route_t        o_done_route
);

  logic   hold_r;
  route_t route_r;
  logic   proc_sel;
  logic   raw_sel;
  logic   proc_ok;
  logic   raw_ok;
  logic   in_xfer;

  //////////////////////////////////////////////////
  // Route selection
  //////////////////////////////////////////////////
  assign in_xfer = net_in.tvalid & net_in.tready;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      hold_r  <= 1'b1;
      route_r <= ROUTE_NONE;
    end else if (i_clear) begin
      hold_r  <= 1'b1;
      route_r <= ROUTE_NONE;
    end else begin
      // Header waiting and someone can take it
      if (hold_r && net_in.tvalid && (proc_out.tready || raw_out.tready)) begin
        hold_r  <= 1'b0;
        route_r <= route_t'({raw_out.tready, proc_out.tready});
      end
      // End of packet, back to waiting for the next header
      if (in_xfer && net_in.tlast) begin
        hold_r  <= 1'b1;
        route_r <= ROUTE_NONE;
      end
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////
  // Route is NONE while holding, so nothing moves
  assign proc_sel = (route_r == ROUTE_PROC) | (route_r == ROUTE_BOTH);
  assign raw_sel  = (route_r == ROUTE_RAW) | (route_r == ROUTE_BOTH);

  // Each selected port must accept, unselected ports don't matter
  assign proc_ok = ~proc_sel | proc_out.tready;
  assign raw_ok  = ~raw_sel | raw_out.tready;

  assign proc_out.tdata  = net_in.tdata;
  assign proc_out.tlast  = net_in.tlast;
  assign raw_out.tdata   = net_in.tdata;
  assign raw_out.tlast   = net_in.tlast;

  // In ROUTE_BOTH a port only sees valid when the other one is ready too,
  // so neither consumer takes a word that the other misses
  assign proc_out.tvalid = net_in.tvalid & proc_sel & raw_ok;
  assign raw_out.tvalid  = net_in.tvalid & raw_sel & proc_ok;
  assign net_in.tready   = (proc_sel | raw_sel) & proc_ok & raw_ok;

  // Finished packet report
  assign o_done_stb   = in_xfer & net_in.tlast;
  assign o_done_route = route_r;

endmodule

`default_nettype wire

/* verilog/source_merge.sv */
// Outbound packet merge
// Two-source round-robin arbiter, locked from the first offered word of a
// packet until its last word is accepted

`timescale 1ns/1ns
`default_nettype none

module source_merge (
  input  wire           ce_clk,
  input  wire           i_rst_n,
  input  wire           i_clear,
  pkt_stream_if.sink    proc_in,
  pkt_stream_if.sink    raw_in,
  pkt_stream_if.source  merged
);

  localparam logic SRC_PROC = 1'b0;
  localparam logic SRC_RAW  = 1'b1;

  logic locked_r;
  logic grant_r;
  logic prio_r;
  logic pick;
  logic sel;
  logic xfer;

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////
  // Round robin between the two sources
  always_comb begin
    if (prio_r == SRC_RAW && raw_in.tvalid) begin
      pick = SRC_RAW;
    end else if (proc_in.tvalid) begin
      pick = SRC_PROC;
    end else begin
      pick = raw_in.tvalid ? SRC_RAW : SRC_PROC;
    end
  end

  assign sel  = locked_r ? grant_r : pick;
  assign xfer = merged.tvalid & merged.tready;

  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      locked_r <= 1'b0;
      grant_r  <= SRC_PROC;
      prio_r   <= SRC_PROC;
    end else if (i_clear) begin
      locked_r <= 1'b0;
      grant_r  <= SRC_PROC;
      prio_r   <= SRC_PROC;
    end else begin
      if (xfer && merged.tlast) begin
        // Other source goes first next time
        locked_r <= 1'b0;
        prio_r   <= ~sel;
      end else if (merged.tvalid) begin
        // Lock as soon as a word is offered so the output stays stable
        locked_r <= 1'b1;
        grant_r  <= sel;
      end
    end
  end

  //////////////////////////////////////////////////
  // Output mux
  //////////////////////////////////////////////////
  assign merged.tdata  = (sel == SRC_RAW) ? raw_in.tdata : proc_in.tdata;
  assign merged.tlast  = (sel == SRC_RAW) ? raw_in.tlast : proc_in.tlast;
  assign merged.tvalid = (sel == SRC_RAW) ? raw_in.tvalid : proc_in.tvalid;

  // Source without the grant is stalled
  assign proc_in.tready = merged.tready & (sel == SRC_PROC);
  assign raw_in.tready  = merged.tready & (sel == SRC_RAW);

endmodule

`default_nettype wire

/* verilog/seqnum_rewrite.sv */
// Outbound sequence number rewrite
// Counts outbound packets and optionally puts the count into each header

`timescale 1ns/1ns
`include "pkt_port_settings.svh"
`default_nettype none

module seqnum_rewrite
  import pkt_port_pkg::*;
(
  input  wire                  ce_clk,
  input  wire                  i_rst_n,
  input  wire                  i_clear,
  input  wire                  i_rewrite_en,
  pkt_stream_if.sink           pkt_in,
  pkt_stream_if.source         pkt_out,
  output logic [`PP_SEQ_W-1:0] o_seq_count
);

  logic                 sof_r;
  logic [`PP_SEQ_W-1:0] seq_cnt_r;
  pkt_hdr_t             hdr_new;
  logic                 xfer;

  assign xfer = pkt_out.tvalid & pkt_out.tready;

  // First word after a last is the next header
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      sof_r     <= 1'b1;
      seq_cnt_r <= '0;
    end else if (i_clear) begin
      sof_r     <= 1'b1;
      seq_cnt_r <= '0;
    end else if (xfer) begin
      sof_r <= pkt_out.tlast;
      if (pkt_out.tlast) begin
        seq_cnt_r <= seq_cnt_r + 1'b1;
      end
    end
  end

  // Header with only the sequence field swapped
  always_comb begin
    hdr_new        = pkt_hdr_t'(pkt_in.tdata);
    hdr_new.seqnum = seq_cnt_r;
  end

  assign pkt_out.tdata  = (i_rewrite_en && sof_r) ? hdr_new : pkt_in.tdata;
  assign pkt_out.tlast  = pkt_in.tlast;
  assign pkt_out.tvalid = pkt_in.tvalid;
  assign pkt_in.tready  = pkt_out.tready;

  assign o_seq_count = seq_cnt_r;

endmodule

`default_nettype wire

/* verilog/pkt_port_top.sv */
// Packet port gateway top
// Inbound steering, outbound merge with sequence rewrite, and control

`timescale 1ns/1ns
`include "pkt_port_settings.svh"
`default_nettype none

module pkt_port_top
  import pkt_port_pkg::*;
(
  input  wire                   ce_clk,
  input  wire                   i_rst_n,
  // Settings and readback
  input  wire                   i_set_stb,
  input  wire [`PP_ADDR_W-1:0]  i_set_addr,
  input  wire [31:0]            i_set_data,
  input  wire                   i_rb_stb,
  input  wire [`PP_ADDR_W-1:0]  i_rb_addr,
  output logic                  o_rb_ack,
  output logic [63:0]           o_rb_data,
  // Inbound network stream
  input  wire [`PP_WORD_W-1:0]  i_net_in_tdata,
  input  wire                   i_net_in_tlast,
  input  wire                   i_net_in_tvalid,
  output logic                  o_net_in_tready,
  // Processing consumer
  output logic [`PP_WORD_W-1:0] o_proc_tdata,
  output logic                  o_proc_tlast,
  output logic                  o_proc_tvalid,
  input  wire                   i_proc_tready,
  // Raw consumer
  output logic [`PP_WORD_W-1:0] o_raw_tdata,
  output logic                  o_raw_tlast,
  output logic                  o_raw_tvalid,
  input  wire                   i_raw_tready,
  // Processing source
  input  wire [`PP_WORD_W-1:0]  i_proc_in_tdata,
  input  wire                   i_proc_in_tlast,
  input  wire                   i_proc_in_tvalid,
  output logic                  o_proc_in_tready,
  // Raw source
  input  wire [`PP_WORD_W-1:0]  i_raw_in_tdata,
  input  wire                   i_raw_in_tlast,
  input  wire                   i_raw_in_tvalid,
  output logic                  o_raw_in_tready,
  // Outbound network stream
  output logic [`PP_WORD_W-1:0] o_net_out_tdata,
  output logic                  o_net_out_tlast,
  output logic                  o_net_out_tvalid,
  input  wire                   i_net_out_tready
);

  logic                 clear;
  logic                 rewrite_en;
  logic                 done_stb;
  route_t               done_route;
  logic [`PP_SEQ_W-1:0] seq_count;

  pkt_stream_if net_in_s ();
  pkt_stream_if proc_out_s ();
  pkt_stream_if raw_out_s ();
  pkt_stream_if proc_in_s ();
  pkt_stream_if raw_in_s ();
  pkt_stream_if merged_s ();
  pkt_stream_if net_out_s ();

  //////////////////////////////////////////////////
  // Port to interface mapping
  //////////////////////////////////////////////////
  assign net_in_s.tdata     = i_net_in_tdata;
  assign net_in_s.tlast     = i_net_in_tlast;
  assign net_in_s.tvalid    = i_net_in_tvalid;
  assign o_net_in_tready    = net_in_s.tready;

  assign o_proc_tdata       = proc_out_s.tdata;
  assign o_proc_tlast       = proc_out_s.tlast;
  assign o_proc_tvalid      = proc_out_s.tvalid;
  assign proc_out_s.tready  = i_proc_tready;

  assign o_raw_tdata        = raw_out_s.tdata;
  assign o_raw_tlast        = raw_out_s.tlast;
  assign o_raw_tvalid       = raw_out_s.tvalid;
  assign raw_out_s.tready   = i_raw_tready;

  assign proc_in_s.tdata    = i_proc_in_tdata;
  assign proc_in_s.tlast    = i_proc_in_tlast;
  assign proc_in_s.tvalid   = i_proc_in_tvalid;
  assign o_proc_in_tready   = proc_in_s.tready;

  assign raw_in_s.tdata     = i_raw_in_tdata;
  assign raw_in_s.tlast     = i_raw_in_tlast;
  assign raw_in_s.tvalid    = i_raw_in_tvalid;
  assign o_raw_in_tready    = raw_in_s.tready;

  assign o_net_out_tdata    = net_out_s.tdata;
  assign o_net_out_tlast    = net_out_s.tlast;
  assign o_net_out_tvalid   = net_out_s.tvalid;
  assign net_out_s.tready   = i_net_out_tready;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////
  port_ctrl port_ctrl_inst (
    .ce_clk       (ce_clk),
    .i_rst_n      (i_rst_n),
    .i_set_stb    (i_set_stb),
    .i_set_addr   (i_set_addr),
    .i_set_data   (i_set_data),
    .i_rb_stb     (i_rb_stb),
    .i_rb_addr    (i_rb_addr),
    .o_rb_ack     (o_rb_ack),
    .o_rb_data    (o_rb_data),
    .o_clear      (clear),
    .o_rewrite_en (rewrite_en),
    .i_done_stb   (done_stb),
    .i_done_route (done_route),
    .i_seq_count  (seq_count),
    .net_mon      (net_in_s.monitor)
  );

  sink_steer sink_steer_inst (
    .ce_clk       (ce_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (clear),
    .net_in       (net_in_s.sink),
    .proc_out     (proc_out_s.source),
    .raw_out      (raw_out_s.source),
    .o_done_stb   (done_stb),
    .o_done_route (done_route)
  );

  source_merge source_merge_inst (
    .ce_clk  (ce_clk),
    .i_rst_n (i_rst_n),
    .i_clear (clear),
    .proc_in (proc_in_s.sink),
    .raw_in  (raw_in_s.sink),
    .merged  (merged_s.source)
  );

  seqnum_rewrite seqnum_rewrite_inst (
    .ce_clk       (ce_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (clear),
    .i_rewrite_en (rewrite_en),
    .pkt_in       (merged_s.sink),
    .pkt_out      (net_out_s.source),
    .o_seq_count  (seq_count)
  );

endmodule

`default_nettype wire

/* tests/pkt_port_props.sv */
// Packet port checkers
// Concurrent assertions on the outbound handshake, the inbound steering and
// packet locking of the outbound merge

`timescale 1ns/1ns
`include "pkt_port_settings.svh"
`default_nettype none

module pkt_port_props
  import pkt_port_pkg::*;
(
  input wire                  ce_clk,
  input wire                  i_rst_n,
  input wire                  o_proc_tvalid,
  input wire                  o_raw_tvalid,
  input wire route_t          done_route,
  input wire [`PP_WORD_W-1:0] o_net_out_tdata,
  input wire                  o_net_out_tlast,
  input wire                  o_net_out_tvalid,
  input wire                  i_net_out_tready,
  input wire                  o_raw_in_tready
);

  logic mid_r;
  logic src_r;
  logic out_xfer;

  assign out_xfer = o_net_out_tvalid & i_net_out_tready;

  // Source of the packet now on net_out, raw when its ready is granted
  always_ff @(posedge ce_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mid_r <= 1'b0;
      src_r <= 1'b0;
    end else if (out_xfer) begin
      mid_r <= ~o_net_out_tlast;
      src_r <= o_raw_in_tready;
    end
  end

  stall_holds_word: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (o_net_out_tvalid && !i_net_out_tready) |=>
      (o_net_out_tvalid && $stable(o_net_out_tdata)))
    else $error("net_out word changed while stalled");

  both_only_in_both_route: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (o_proc_tvalid && o_raw_tvalid) |-> (done_route == ROUTE_BOTH))
    else $error("proc and raw both valid outside ROUTE_BOTH");

  merge_locked_in_packet: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (out_xfer && mid_r) |-> (o_raw_in_tready == src_r))
    else $error("merge switched source inside a packet");

endmodule

`default_nettype wire

/* tests/pkt_port_tb.sv */
// Packet port testbench
// Inbound steering, outbound merge and sequence rewrite, counters and readback

`timescale 1ns/1ns
`include "pkt_port_settings.svh"
`default_nettype none

module pkt_port_tb import pkt_port_pkg::*;;

  localparam int TIMEOUT = 2000;

  logic ce_clk;
  logic i_rst_n;
  logic i_set_stb;
  logic [`PP_ADDR_W-1:0] i_set_addr;
  logic [31:0] i_set_data;
  logic i_rb_stb;
  logic [`PP_ADDR_W-1:0] i_rb_addr;
  logic o_rb_ack;
  logic [63:0] o_rb_data;
  logic [63:0] i_net_in_tdata;
  logic i_net_in_tlast;
  logic i_net_in_tvalid;
  logic o_net_in_tready;
  logic [63:0] o_proc_tdata;
  logic o_proc_tlast;
  logic o_proc_tvalid;
  logic i_proc_tready;
  logic [63:0] o_raw_tdata;
  logic o_raw_tlast;
  logic o_raw_tvalid;
  logic i_raw_tready;
  logic [63:0] i_proc_in_tdata;
  logic i_proc_in_tlast;
  logic i_proc_in_tvalid;
  logic o_proc_in_tready;
  logic [63:0] i_raw_in_tdata;
  logic i_raw_in_tlast;
  logic i_raw_in_tvalid;
  logic o_raw_in_tready;
  logic [63:0] o_net_out_tdata;
  logic o_net_out_tlast;
  logic o_net_out_tvalid;
  logic i_net_out_tready;

  integer seed = 32'hf30a_67ef;
  logic stall_en = 1'b0;
  logic [31:0] next_sid = 32'h100;
  int err_cnt = 0;
  int err_mark = 0;
  int test_num = 0;
  int pass_cnt = 0;

  // Model state
  logic [15:0] m_in = '0;
  logic [15:0] m_proc = '0;
  logic [15:0] m_raw = '0;
  logic [`PP_SEQ_W-1:0] m_seq = '0;
  logic m_rewrite = 1'b0;

  // Words are {last, data}
  logic [64:0] exp_proc_q[$];
  logic [64:0] exp_raw_q[$];
  logic [64:0] got_proc_q[$];
  logic [64:0] got_raw_q[$];
  logic [64:0] src_proc_q[$];
  logic [64:0] src_raw_q[$];
  logic [64:0] got_net_q[$];

  pkt_port_top pkt_port_top_inst (.*);

  bind pkt_port_top pkt_port_props props_inst (
    .ce_clk           (ce_clk),
    .i_rst_n          (i_rst_n),
    .o_proc_tvalid    (o_proc_tvalid),
    .o_raw_tvalid     (o_raw_tvalid),
    .done_route       (done_route),
    .o_net_out_tdata  (o_net_out_tdata),
    .o_net_out_tlast  (o_net_out_tlast),
    .o_net_out_tvalid (o_net_out_tvalid),
    .i_net_out_tready (i_net_out_tready),
    .o_raw_in_tready  (o_raw_in_tready)
  );

  initial begin
    ce_clk = 1'b0;
    forever #10 ce_clk = ~ce_clk;
  end

  // Collectors sample mid-cycle where outputs are settled
  always @(negedge ce_clk) begin
    if (i_rst_n) begin
      if (o_proc_tvalid && i_proc_tready) got_proc_q.push_back({o_proc_tlast, o_proc_tdata});
      if (o_raw_tvalid && i_raw_tready) got_raw_q.push_back({o_raw_tlast, o_raw_tdata});
      if (o_net_out_tvalid && i_net_out_tready) begin
        got_net_q.push_back({o_net_out_tlast, o_net_out_tdata});
      end
    end
  end

  // Random stalls on the processing consumer
  always @(posedge ce_clk) begin
    if (stall_en) i_proc_tready <= (($random(seed) & 3) != 0);
  end

  // Random back-pressure on the outbound stream
  always @(posedge ce_clk) begin
    if (i_rst_n) i_net_out_tready <= (($random(seed) & 3) != 0);
  end

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [63:0] expect_header(input logic [63:0] hdr, input logic en,
                                                input logic [`PP_SEQ_W-1:0] seq);
    pkt_hdr_t h;
    h = pkt_hdr_t'(hdr);
    if (en) h.seqnum = seq;
    return h;
  endfunction

  function automatic logic [63:0] new_header(input int len);
    pkt_hdr_t h;
    h.pkt_type = 4'($random(seed));
    h.seqnum   = 12'($random(seed));
    h.pkt_len  = 16'(len * 8);
    h.sid      = next_sid;
    next_sid   = next_sid + 1;
    return h;
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic report_timeout(input string what);
    $display("Timeout: no handshake on %s", what);
    $display("Done: errors found");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////
  task automatic send_net(input route_t route, input bit stall);
    logic [64:0] pkt [6];
    int len;
    int n;
    len = 2 + int'({$random(seed)} % 5);
    pkt[0] = {1'b0, new_header(len)};
    for (int i = 1; i < len; i++) pkt[i] = {(i == len - 1), $random(seed), $random(seed)};
    for (int i = 0; i < len; i++) begin
      if (route[0]) exp_proc_q.push_back(pkt[i]);
      if (route[1]) exp_raw_q.push_back(pkt[i]);
    end
    m_in++;
    if (route[0]) m_proc++;
    if (route[1]) m_raw++;
    // Ready levels at the header pick the route
    i_proc_tready <= route[0];
    i_raw_tready  <= route[1];
    for (int i = 0; i < len; i++) begin
      i_net_in_tdata  <= pkt[i][63:0];
      i_net_in_tlast  <= pkt[i][64];
      i_net_in_tvalid <= 1'b1;
      n = 0;
      do begin
        @(negedge ce_clk);
        n++;
        if (n > TIMEOUT) report_timeout("net_in");
      end while (!o_net_in_tready);
      @(posedge ce_clk);
      if (i == 0 && stall) stall_en <= 1'b1;
    end
    i_net_in_tvalid <= 1'b0;
    stall_en <= 1'b0;
    @(posedge ce_clk);
  endtask

  task automatic send_src(input bit is_raw, input int n_pkts);
    logic [64:0] pkt [6];
    int len;
    int n;
    for (int p = 0; p < n_pkts; p++) begin
      len = 2 + int'({$random(seed)} % 5);
      pkt[0] = {1'b0, new_header(len)};
      for (int i = 1; i < len; i++) pkt[i] = {(i == len - 1), $random(seed), $random(seed)};
      for (int i = 0; i < len; i++) begin
        if (is_raw) src_raw_q.push_back(pkt[i]);
        else src_proc_q.push_back(pkt[i]);
      end
      for (int i = 0; i < len; i++) begin
        if (is_raw) begin
          i_raw_in_tdata  <= pkt[i][63:0];
          i_raw_in_tlast  <= pkt[i][64];
          i_raw_in_tvalid <= 1'b1;
        end else begin
          i_proc_in_tdata  <= pkt[i][63:0];
          i_proc_in_tlast  <= pkt[i][64];
          i_proc_in_tvalid <= 1'b1;
        end
        n = 0;
        do begin
          @(negedge ce_clk);
          n++;
          if (n > TIMEOUT) report_timeout(is_raw ? "raw_in" : "proc_in");
        end while (!(is_raw ? o_raw_in_tready : o_proc_in_tready));
        @(posedge ce_clk);
        // Occasional idle cycle between words
        if (($random(seed) & 3) == 0) begin
          if (is_raw) i_raw_in_tvalid <= 1'b0;
          else i_proc_in_tvalid <= 1'b0;
          @(posedge ce_clk);
        end
      end
    end
    if (is_raw) i_raw_in_tvalid <= 1'b0;
    else i_proc_in_tvalid <= 1'b0;
  endtask

  task automatic write_set(input logic [`PP_ADDR_W-1:0] addr, input logic [31:0] data);
    i_set_stb  <= 1'b1;
    i_set_addr <= addr;
    i_set_data <= data;
    @(posedge ce_clk);
    i_set_stb <= 1'b0;
    repeat (2) @(posedge ce_clk);
  endtask

  task automatic read_rb(input logic [`PP_ADDR_W-1:0] addr, output logic [63:0] data);
    i_rb_stb  <= 1'b1;
    i_rb_addr <= addr;
    @(posedge ce_clk);
    i_rb_stb <= 1'b0;
    @(negedge ce_clk);
    if (!o_rb_ack) report_error("no readback ack one cycle after the strobe");
    data = o_rb_data;
    @(posedge ce_clk);
  endtask

  //////////////////////////////////////////////////
  // Comparison
  //////////////////////////////////////////////////
  task automatic compare_queue(input string name, input logic [64:0] got[$],
                               input logic [64:0] exp[$]);
    if (got.size() != exp.size()) begin
      report_error($sformatf("%s got %0d words, expected %0d", name, got.size(), exp.size()));
    end
    for (int i = 0; i < got.size() && i < exp.size(); i++) begin
      if (got[i] !== exp[i]) begin
        report_error($sformatf("%s word %0d is %h, expected %h", name, i, got[i], exp[i]));
      end
    end
  endtask

  task automatic check_inbound();
    compare_queue("proc port", got_proc_q, exp_proc_q);
    compare_queue("raw port", got_raw_q, exp_raw_q);
    got_proc_q.delete();
    got_raw_q.delete();
    exp_proc_q.delete();
    exp_raw_q.delete();
  endtask

  task automatic check_outbound();
    int idx;
    int prev;
    bit from_raw;
    logic [64:0] w;
    logic [64:0] s;
    logic [64:0] e;
    idx = 0;
    prev = -1;
    while (idx < got_net_q.size()) begin
      w = got_net_q[idx];
      if (src_proc_q.size() > 0 && src_proc_q[0][31:0] == w[31:0]) from_raw = 1'b0;
      else if (src_raw_q.size() > 0 && src_raw_q[0][31:0] == w[31:0]) from_raw = 1'b1;
      else begin
        report_error($sformatf("net_out header %h matches no waiting packet", w));
        break;
      end
      if (prev == int'(from_raw) && src_proc_q.size() > 0 && src_raw_q.size() > 0) begin
        report_error("net_out did not alternate between busy sources");
      end
      prev = int'(from_raw);
      s = from_raw ? src_raw_q.pop_front() : src_proc_q.pop_front();
      e = {s[64], expect_header(s[63:0], m_rewrite, m_seq)};
      if (w !== e) report_error($sformatf("net_out header is %h, expected %h", w, e));
      idx++;
      while (!s[64] && idx < got_net_q.size()) begin
        w = got_net_q[idx];
        s = from_raw ? src_raw_q.pop_front() : src_proc_q.pop_front();
        if (w !== s) report_error($sformatf("net_out word is %h, expected %h", w, s));
        idx++;
      end
      m_seq++;
    end
    if (src_proc_q.size() > 0 || src_raw_q.size() > 0) begin
      report_error("packets sent on the sources never left net_out");
    end
    got_net_q.delete();
    src_proc_q.delete();
    src_raw_q.delete();
  endtask

  task automatic expect_counts();
    logic [63:0] d;
    logic [63:0] e;
    read_rb(`PP_RB_COUNTS, d);
    e = {4'd0, m_seq, m_raw, m_proc, m_in};
    if (d !== e) report_error($sformatf("counter readback %h, expected %h", d, e));
  endtask

  task automatic expect_cfg(input logic [31:0] cfg);
    logic [63:0] d;
    read_rb(`PP_RB_CFG, d);
    if (d !== {32'd0, cfg}) report_error($sformatf("config readback %h, expected %h", d, cfg));
  endtask

  task automatic clear_model();
    m_in   = '0;
    m_proc = '0;
    m_raw  = '0;
    m_seq  = '0;
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (err_cnt == err_mark) pass_cnt++;
    $display("Test %0d %s: %s", test_num, name, (err_cnt == err_mark) ? "passed" : "FAILED");
    err_mark = err_cnt;
    @(posedge ce_clk);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    i_rst_n = 1'b0;
    i_set_stb = 1'b0;
    i_set_addr = '0;
    i_set_data = '0;
    i_rb_stb = 1'b0;
    i_rb_addr = '0;
    i_net_in_tdata = '0;
    i_net_in_tlast = 1'b0;
    i_net_in_tvalid = 1'b0;
    i_proc_tready = 1'b0;
    i_raw_tready = 1'b0;
    i_proc_in_tdata = '0;
    i_proc_in_tlast = 1'b0;
    i_proc_in_tvalid = 1'b0;
    i_raw_in_tdata = '0;
    i_raw_in_tlast = 1'b0;
    i_raw_in_tvalid = 1'b0;
    i_net_out_tready = 1'b1;
    repeat (8) @(posedge ce_clk);
    i_rst_n <= 1'b1;
    @(posedge ce_clk);

    repeat (3) send_net(ROUTE_PROC, 1'b0);
    repeat (3) send_net(ROUTE_RAW, 1'b0);
    @(negedge ce_clk);
    check_inbound();
    finish_test("single route steering");

    repeat (4) send_net(ROUTE_BOTH, 1'b1);
    @(negedge ce_clk);
    check_inbound();
    finish_test("both routes with stalls");

    fork
      send_src(1'b0, 4);
      send_src(1'b1, 4);
    join
    @(negedge ce_clk);
    check_outbound();
    finish_test("outbound merge");

    write_set(`PP_REG_CFG, 32'd1);
    m_rewrite = 1'b1;
    write_set(`PP_REG_CLEAR, 32'd0);
    clear_model();
    fork
      send_src(1'b0, 3);
      send_src(1'b1, 3);
    join
    @(negedge ce_clk);
    check_outbound();
    finish_test("sequence rewrite");

    repeat (2) send_net(ROUTE_PROC, 1'b0);
    send_net(ROUTE_BOTH, 1'b0);
    expect_counts();
    expect_cfg(32'd1);
    write_set(`PP_REG_CLEAR, 32'd0);
    clear_model();
    expect_counts();
    expect_cfg(32'd1);
    send_src(1'b0, 1);
    @(negedge ce_clk);
    check_outbound();
    expect_counts();
    finish_test("readback and clear");

    $display("Tests: %0d  passed: %0d  errors: %0d", test_num, pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verilog
verilog/pkt_port_pkg.sv
verilog/pkt_stream_if.sv
verilog/port_ctrl.sv
verilog/sink_steer.sv
verilog/source_merge.sv
verilog/seqnum_rewrite.sv
verilog/pkt_port_top.sv
tests/pkt_port_props.sv
tests/pkt_port_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run the simulation, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pkt_port_tb \
  -f sources.f -o pkt_port_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/pkt_port_sim > sim.log 2>&1 \
  || echo "Done: errors found" >> sim.log

grep -q "Done: errors found" sim.log \
  && { echo "Simulation FAILED, see sim.log"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
